//--- Makefile
# Verilator build and run of the vector execute stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= vex_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- logic/vex_execute_stage.sv
// Two-lane vector execute stage, top level between decode and memory with stall/flush/busy control
`default_nettype none
`timescale 1ns/1ps

module vex_execute_stage (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                in_valid,
  input  vex_pkg::fu_t        fu_type,
  input  vex_pkg::alu_op_t    alu_op,
  input  vex_pkg::src_t       rs1_src,
  input  vex_pkg::src_t       rs2_src,
  input  vex_pkg::elem_t      vs1_lane0,
  input  vex_pkg::elem_t      vs1_lane1,
  input  vex_pkg::elem_t      vs2_lane0,
  input  vex_pkg::elem_t      vs2_lane1,
  input  vex_pkg::elem_t      xs1,
  input  vex_pkg::elem_t      xs2,
  input  vex_pkg::elem_t      imm,
  input  vex_pkg::vl_t        vl,
  input  vex_pkg::elem_idx_t  elem_idx0,
  input  vex_pkg::elem_idx_t  elem_idx1,
  input  logic                lane_en0,
  input  logic                lane_en1,
  input  logic                strided,
  input  logic                indexed,
  input  vex_pkg::elem_t      stride_val,
  input  vex_pkg::elem_t      storedata0,
  input  vex_pkg::elem_t      storedata1,
  input  vex_pkg::reg_idx_t   vd,
  input  logic                stall,
  input  logic                flush,
  output logic                busy,
  output logic                out_valid,
  output vex_pkg::fu_t        out_fu,
  output vex_pkg::elem_t      out_result0,
  output vex_pkg::elem_t      out_result1,
  output logic                out_wen0,
  output logic                out_wen1,
  output vex_pkg::elem_t      out_storedata0,
  output vex_pkg::elem_t      out_storedata1,
  output vex_pkg::elem_idx_t  out_elem_idx0,
  output vex_pkg::elem_idx_t  out_elem_idx1,
  output vex_pkg::reg_idx_t   out_vd
);

  vex_pkg::elem_t op_a0, op_a1, op_b0, op_b1;
  vex_pkg::elem_t addr_base0, addr_base1, addr_off0, addr_off1;
  vex_pkg::elem_t addr_step, addr_buffer;
  vex_pkg::elem_t lane_res0, lane_res1, lane_addr0, lane_addr1;
  vex_pkg::elem_t iota_res0, iota_res1;
  logic           lane_busy0, lane_busy1;
  logic           mul_pending, is_mem;
  logic           single_fire, mul_issue, mul_finish, capture;

  // Operand A
  always_comb begin
    case (rs1_src)
      vex_pkg::SRC_V: begin op_a0 = vs1_lane0; op_a1 = vs1_lane1; end
      vex_pkg::SRC_I: begin op_a0 = imm;       op_a1 = imm;       end
      vex_pkg::SRC_X: begin op_a0 = xs1;       op_a1 = xs1;       end
      default:        begin op_a0 = '0;        op_a1 = '0;        end
    endcase
  end

  // Operand B
  always_comb begin
    case (rs2_src)
      vex_pkg::SRC_V: begin op_b0 = vs2_lane0; op_b1 = vs2_lane1; end
      vex_pkg::SRC_I: begin op_b0 = imm;       op_b1 = imm;       end
      vex_pkg::SRC_X: begin op_b0 = xs2;       op_b1 = xs2;       end
      default:        begin op_b0 = '0;        op_b1 = '0;        end
    endcase
  end

  // Lane 1 address chains off lane 0 unless indexed
  assign addr_step  = strided ? stride_val : vex_pkg::UNIT_STRIDE;
  assign addr_base0 = (indexed || elem_idx0 == '0) ? xs1 : addr_buffer;
  assign addr_off0  = indexed ? vs2_lane0 : '0;
  assign addr_base1 = indexed ? xs1 : lane_addr0;
  assign addr_off1  = indexed ? vs2_lane1 : addr_step;

  // Issue and completion
  assign is_mem      = (fu_type == vex_pkg::FU_LOAD) || (fu_type == vex_pkg::FU_STORE);
  assign busy        = lane_busy0 | lane_busy1;
  assign single_fire = in_valid && (fu_type != vex_pkg::FU_MUL) && !busy && !mul_pending;
  assign mul_issue   = in_valid && (fu_type == vex_pkg::FU_MUL) && !busy && !mul_pending &&
                       !stall && !flush;
  assign mul_finish  = mul_pending && !busy;
  assign capture     = single_fire || mul_finish;

  vex_iota u_iota (
    .mask_bits ({vs2_lane1, vs2_lane0}),
    .vl        (vl),
    .idx0      (elem_idx0),
    .idx1      (elem_idx1),
    .res0      (iota_res0),
    .res1      (iota_res1)
  );

  vex_lane lane0 (
    .CLK         (CLK),
    .nRST        (nRST),
    .alu_op      (alu_op),
    .fu_type     (fu_type),
    .op_a        (op_a0),
    .op_b        (op_b0),
    .mul_start   (mul_issue && lane_en0),
    .abort       (flush),
    .addr_base   (addr_base0),
    .addr_offset (addr_off0),
    .iota_res    (iota_res0),
    .result      (lane_res0),
    .addr        (lane_addr0),
    .busy        (lane_busy0)
  );

  vex_lane lane1 (
    .CLK         (CLK),
    .nRST        (nRST),
    .alu_op      (alu_op),
    .fu_type     (fu_type),
    .op_a        (op_a1),
    .op_b        (op_b1),
    .mul_start   (mul_issue && lane_en1),
    .abort       (flush),
    .addr_base   (addr_base1),
    .addr_offset (addr_off1),
    .iota_res    (iota_res1),
    .result      (lane_res1),
    .addr        (lane_addr1),
    .busy        (lane_busy1)
  );

  // Multiply in flight until the latch takes its result
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mul_pending <= 1'b0;
    end else if (flush) begin
      mul_pending <= 1'b0;
    end else if (mul_issue) begin
      mul_pending <= 1'b1;
    end else if (mul_finish && !stall) begin
      mul_pending <= 1'b0;
    end
  end

  // Next element pair's base for unit and strided runs
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      addr_buffer <= '0;
    end else if (single_fire && is_mem && !indexed && !stall && !flush) begin
      addr_buffer <= lane_addr1 + addr_step;
    end
  end

  // Pipeline latch, control part
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
      out_wen0  <= 1'b0;
      out_wen1  <= 1'b0;
    end else if (flush) begin
      out_valid <= 1'b0;
      out_wen0  <= 1'b0;
      out_wen1  <= 1'b0;
    end else if (!stall) begin
      out_valid <= capture;
      out_wen0  <= capture && lane_en0 && (fu_type != vex_pkg::FU_STORE);
      out_wen1  <= capture && lane_en1 && (fu_type != vex_pkg::FU_STORE);
    end
  end

  // Pipeline latch, payload part
  always_ff @(posedge CLK) begin
    if (capture && !stall && !flush) begin
      out_fu         <= fu_type;
      out_result0    <= lane_res0;
      out_result1    <= lane_res1;
      out_storedata0 <= storedata0;
      out_storedata1 <= storedata1;
      out_elem_idx0  <= elem_idx0;
      out_elem_idx1  <= elem_idx1;
      out_vd         <= vd;
    end
  end

  a_wen_needs_valid: assert property (
    @(posedge CLK) disable iff (!nRST) (out_wen0 || out_wen1) |-> out_valid)
    else $error("write enable without valid result");

  // Upstream holds the instruction while a multiply runs
  a_inputs_held: assert property (
    @(posedge CLK) disable iff (!nRST || flush)
    busy |-> $stable({in_valid, fu_type, alu_op, rs1_src, rs2_src, vs1_lane0, vs1_lane1,
                      vs2_lane0, vs2_lane1, xs1, xs2, imm, lane_en0, lane_en1, vd}))
    else $error("inputs changed while busy");

endmodule

`default_nettype wire

//--- logic/vex_iota.sv
// Iota unit, counts mask bits below each lane's element index and below vl
`default_nettype none
`timescale 1ns/1ps

module vex_iota (
  input  logic [vex_pkg::MASK_W-1:0] mask_bits,
  input  vex_pkg::vl_t               vl,
  input  vex_pkg::elem_idx_t         idx0,
  input  vex_pkg::elem_idx_t         idx1,
  output vex_pkg::elem_t             res0,
  output vex_pkg::elem_t             res1
);

  vex_pkg::vl_t bound0;
  vex_pkg::vl_t bound1;

  // Popcount of the bits under bound
  function automatic vex_pkg::elem_t count_below(
    input logic [vex_pkg::MASK_W-1:0] bits,
    input vex_pkg::vl_t               bound
  );
    vex_pkg::elem_t cnt;
    cnt = '0;
    for (int i = 0; i < vex_pkg::MASK_W; i++) begin
      if (vex_pkg::vl_t'(i) < bound) begin
        cnt = cnt + vex_pkg::elem_t'(bits[i]);
      end
    end
    return cnt;
  endfunction

  // Tighter of index and vl
  assign bound0 = ({1'b0, idx0} < vl) ? {1'b0, idx0} : vl;
  assign bound1 = ({1'b0, idx1} < vl) ? {1'b0, idx1} : vl;

  assign res0 = count_below(mask_bits, bound0);
  assign res1 = count_below(mask_bits, bound1);

endmodule

`default_nettype wire

//--- logic/vex_lane.sv
// One 32-bit vector lane with ALU, address adder and multiply sequencer, result picked by unit
`default_nettype none
`timescale 1ns/1ps

module vex_lane (
  input  logic              CLK,
  input  logic              nRST,
  input  vex_pkg::alu_op_t  alu_op,
  input  vex_pkg::fu_t      fu_type,
  input  vex_pkg::elem_t    op_a,
  input  vex_pkg::elem_t    op_b,
  input  logic              mul_start,
  input  logic              abort,
  input  vex_pkg::elem_t    addr_base,
  input  vex_pkg::elem_t    addr_offset,
  input  vex_pkg::elem_t    iota_res,
  output vex_pkg::elem_t    result,
  output vex_pkg::elem_t    addr,
  output logic              busy
);

  vex_pkg::elem_t alu_res;
  vex_pkg::elem_t mul_res;
  logic [4:0]     shamt;

  vex_mul_seq u_mul (
    .CLK          (CLK),
    .nRST         (nRST),
    .start        (mul_start),
    .abort        (abort),
    .multiplicand (op_a),
    .multiplier   (op_b),
    .product      (mul_res),
    .busy         (busy)
  );

  // Shifts only look at the low five bits
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      vex_pkg::ALU_ADD: alu_res = op_a + op_b;
      vex_pkg::ALU_SUB: alu_res = op_a - op_b;
      vex_pkg::ALU_AND: alu_res = op_a & op_b;
      vex_pkg::ALU_OR:  alu_res = op_a | op_b;
      vex_pkg::ALU_XOR: alu_res = op_a ^ op_b;
      vex_pkg::ALU_SLL: alu_res = op_a << shamt;
      vex_pkg::ALU_SRL: alu_res = op_a >> shamt;
      vex_pkg::ALU_MIN: begin
        // Signed compare
        if ($signed(op_a) < $signed(op_b)) begin
          alu_res = op_a;
        end else begin
          alu_res = op_b;
        end
      end
      vex_pkg::ALU_MAX: begin
        if ($signed(op_a) > $signed(op_b)) begin
          alu_res = op_a;
        end else begin
          alu_res = op_b;
        end
      end
      default: alu_res = '0;
    endcase
  end

  // Address generation
  assign addr = addr_base + addr_offset;

  always_comb begin
    case (fu_type)
      vex_pkg::FU_ALU:   result = alu_res;
      vex_pkg::FU_MUL:   result = mul_res;
      vex_pkg::FU_IOTA:  result = iota_res;
      vex_pkg::FU_LOAD,
      vex_pkg::FU_STORE: result = addr;
      default:           result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/vex_mul_seq.sv
// Shift-add multiplier sequencer for one lane, stops early once the multiplier runs out of ones
`default_nettype none
`timescale 1ns/1ps

module vex_mul_seq (
  input  logic           CLK,
  input  logic           nRST,
  input  logic           start,
  input  logic           abort,
  input  vex_pkg::elem_t multiplicand,
  input  vex_pkg::elem_t multiplier,
  output vex_pkg::elem_t product,
  output logic           busy
);

  vex_pkg::mul_state_t state, next_state;
  vex_pkg::elem_t      mcand;
  vex_pkg::elem_t      mplier;
  vex_pkg::elem_t      acc;
  logic                cnt_step;
  logic                cnt_at_limit;
  logic                last_step;

  // Limit is the index of the final step
  vex_step_counter u_steps (
    .CLK      (CLK),
    .nRST     (nRST),
    .load     (start),
    .step     (cnt_step),
    .limit    (vex_pkg::step_t'(vex_pkg::MUL_MAX_STEPS - 1)),
    .count    (),
    .at_limit (cnt_at_limit)
  );

  // Nothing left to add after this shift
  assign last_step = (mplier[vex_pkg::ELEM_W-1:1] == '0) || cnt_at_limit;
  assign cnt_step  = (state == vex_pkg::MUL_RUN) && !last_step;

  always_comb begin
    next_state = state;
    case (state)
      vex_pkg::MUL_IDLE: if (start) next_state = vex_pkg::MUL_RUN;
      vex_pkg::MUL_RUN:  if (last_step) next_state = vex_pkg::MUL_DONE;
      vex_pkg::MUL_DONE: next_state = vex_pkg::MUL_IDLE;
      default:           next_state = vex_pkg::MUL_IDLE;
    endcase
    if (abort) begin
      next_state = vex_pkg::MUL_IDLE;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= vex_pkg::MUL_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Datapath, product stays put once finished
  always_ff @(posedge CLK) begin
    if (start) begin
      mcand  <= multiplicand;
      mplier <= multiplier;
      acc    <= '0;
    end else if (state == vex_pkg::MUL_RUN) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign product = acc;
  assign busy    = (state == vex_pkg::MUL_RUN);

  // Issue logic upstream has to wait for the sequencer to go idle
  a_start_when_idle: assert property (
    @(posedge CLK) disable iff (!nRST) start |-> (state == vex_pkg::MUL_IDLE))
    else $error("multiply started while sequencer not idle");

endmodule

`default_nettype wire

//--- logic/vex_pkg.sv
// Shared widths, types and constants for the vector execute stage, referenced by scoped name
`default_nettype none

package vex_pkg;

  // Basic widths
  localparam int ELEM_W = 32;
  localparam int IDX_W  = 6;
  localparam int VL_W   = 7;
  localparam int REG_W  = 5;
  localparam int STEP_W = 6;

  // Iota mask spans both lanes' vs2 words
  localparam int MASK_W = 2 * ELEM_W;

  typedef logic [ELEM_W-1:0] elem_t;
  typedef logic [IDX_W-1:0]  elem_idx_t;
  typedef logic [VL_W-1:0]   vl_t;
  typedef logic [REG_W-1:0]  reg_idx_t;
  typedef logic [STEP_W-1:0] step_t;

  typedef enum logic [2:0] {
    FU_ALU,
    FU_MUL,
    FU_IOTA,
    FU_LOAD,
    FU_STORE
  } fu_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_MIN,
    ALU_MAX
  } alu_op_t;

  typedef enum logic [1:0] {
    SRC_V,
    SRC_I,
    SRC_X
  } src_t;

  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_RUN,
    MUL_DONE
  } mul_state_t;

  // Byte stride of a unit-stride access
  localparam elem_t UNIT_STRIDE = 32'd4;

  // One step per multiplier bit
  localparam int MUL_MAX_STEPS = 32;

endpackage

`default_nettype wire

//--- logic/vex_step_counter.sv
// Loadable step counter with a limit flag, counts the iterations of the multiply sequencer
`default_nettype none
`timescale 1ns/1ps

module vex_step_counter (
  input  logic           CLK,
  input  logic           nRST,
  input  logic           load,
  input  logic           step,
  input  vex_pkg::step_t limit,
  output vex_pkg::step_t count,
  output logic           at_limit
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else if (load) begin
      count <= '0;
    end else if (step) begin
      count <= count + 1'b1;
    end
  end

  assign at_limit = (count == limit);

  // The owner must stop stepping once the limit is hit
  a_count_in_range: assert property (@(posedge CLK) disable iff (!nRST) count <= limit)
    else $error("step counter passed its limit");

endmodule

`default_nettype wire

//--- sources.f
logic/vex_pkg.sv
logic/vex_step_counter.sv
logic/vex_mul_seq.sv
logic/vex_lane.sv
logic/vex_iota.sv
logic/vex_execute_stage.sv
tests/vex_tb.sv

//--- tests/vex_tb.sv
// Directed testbench that drives the two-lane vector execute stage as the simulation top
`default_nettype none
`timescale 1ns/1ps

module vex_tb;

  localparam int WAIT_LIMIT = 60;

  logic               CLK;
  logic               nRST;
  logic               in_valid;
  vex_pkg::fu_t       fu_type;
  vex_pkg::alu_op_t   alu_op;
  vex_pkg::src_t      rs1_src;
  vex_pkg::src_t      rs2_src;
  vex_pkg::elem_t     vs1_lane0;
  vex_pkg::elem_t     vs1_lane1;
  vex_pkg::elem_t     vs2_lane0;
  vex_pkg::elem_t     vs2_lane1;
  vex_pkg::elem_t     xs1;
  vex_pkg::elem_t     xs2;
  vex_pkg::elem_t     imm;
  vex_pkg::vl_t       vl;
  vex_pkg::elem_idx_t elem_idx0;
  vex_pkg::elem_idx_t elem_idx1;
  logic               lane_en0;
  logic               lane_en1;
  logic               strided;
  logic               indexed;
  vex_pkg::elem_t     stride_val;
  vex_pkg::elem_t     storedata0;
  vex_pkg::elem_t     storedata1;
  vex_pkg::reg_idx_t  vd;
  logic               stall;
  logic               flush;
  logic               busy;
  logic               out_valid;
  vex_pkg::fu_t       out_fu;
  vex_pkg::elem_t     out_result0;
  vex_pkg::elem_t     out_result1;
  logic               out_wen0;
  logic               out_wen1;
  vex_pkg::elem_t     out_storedata0;
  vex_pkg::elem_t     out_storedata1;
  vex_pkg::elem_idx_t out_elem_idx0;
  vex_pkg::elem_idx_t out_elem_idx1;
  vex_pkg::reg_idx_t  out_vd;

  integer seed;
  int     errors;
  int     checks;

  vex_execute_stage uut (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  function automatic vex_pkg::elem_t rand_elem();
    return $random(seed);
  endfunction

  function automatic vex_pkg::elem_t pick_src(input vex_pkg::src_t src, input vex_pkg::elem_t vreg,
                                              input vex_pkg::elem_t immv, input vex_pkg::elem_t xreg);
    case (src)
      vex_pkg::SRC_V: return vreg;
      vex_pkg::SRC_I: return immv;
      default:        return xreg;
    endcase
  endfunction

  // Expected ALU value with signed MIN and MAX
  function automatic vex_pkg::elem_t alu_model(input vex_pkg::alu_op_t op, input vex_pkg::elem_t a,
                                               input vex_pkg::elem_t b);
    case (op)
      vex_pkg::ALU_ADD: return a + b;
      vex_pkg::ALU_SUB: return a - b;
      vex_pkg::ALU_AND: return a & b;
      vex_pkg::ALU_OR:  return a | b;
      vex_pkg::ALU_XOR: return a ^ b;
      vex_pkg::ALU_SLL: return a << b[4:0];
      vex_pkg::ALU_SRL: return a >> b[4:0];
      vex_pkg::ALU_MIN: return ($signed(a) < $signed(b)) ? a : b;
      vex_pkg::ALU_MAX: return ($signed(a) > $signed(b)) ? a : b;
      default:          return '0;
    endcase
  endfunction

  // Set mask bits under both the element index and vl
  function automatic vex_pkg::elem_t mask_count(input logic [63:0] mask, input int vlen,
                                                input int idx);
    vex_pkg::elem_t n;
    n = '0;
    for (int i = 0; i < 64; i++) begin
      if (i < idx && i < vlen && mask[i]) begin
        n = n + 1;
      end
    end
    return n;
  endfunction

  task automatic check_val(input string name, input vex_pkg::elem_t got, input vex_pkg::elem_t exp);
    checks++;
    assert (got === exp)
    else begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic init_inputs();
    nRST       = 1'b0;
    in_valid   = 1'b0;
    fu_type    = vex_pkg::FU_ALU;
    alu_op     = vex_pkg::ALU_ADD;
    rs1_src    = vex_pkg::SRC_V;
    rs2_src    = vex_pkg::SRC_V;
    vs1_lane0  = '0;
    vs1_lane1  = '0;
    vs2_lane0  = '0;
    vs2_lane1  = '0;
    xs1        = '0;
    xs2        = '0;
    imm        = '0;
    vl         = '0;
    elem_idx0  = '0;
    elem_idx1  = '0;
    lane_en0   = 1'b0;
    lane_en1   = 1'b0;
    strided    = 1'b0;
    indexed    = 1'b0;
    stride_val = '0;
    storedata0 = '0;
    storedata1 = '0;
    vd         = '0;
    stall      = 1'b0;
    flush      = 1'b0;
  endtask

  // Called right after a rising edge
  task automatic drive_operands(input vex_pkg::elem_t v1a, input vex_pkg::elem_t v1b,
                                input vex_pkg::elem_t v2a, input vex_pkg::elem_t v2b,
                                input vex_pkg::elem_t x1, input vex_pkg::elem_t x2,
                                input vex_pkg::elem_t im);
    vs1_lane0 <= v1a;
    vs1_lane1 <= v1b;
    vs2_lane0 <= v2a;
    vs2_lane1 <= v2b;
    xs1       <= x1;
    xs2       <= x2;
    imm       <= im;
  endtask

  task automatic drive_op(input vex_pkg::fu_t fu, input vex_pkg::alu_op_t op,
                          input vex_pkg::src_t s1, input vex_pkg::src_t s2,
                          input logic en0, input logic en1);
    fu_type  <= fu;
    alu_op   <= op;
    rs1_src  <= s1;
    rs2_src  <= s2;
    lane_en0 <= en0;
    lane_en1 <= en1;
    in_valid <= 1'b1;
  endtask

  task automatic wait_valid(output int cycles);
    cycles = 0;
    @(negedge CLK);
    while (!out_valid && cycles < WAIT_LIMIT) begin
      @(negedge CLK);
      cycles++;
    end
    if (!out_valid) begin
      errors++;
      $display("Timeout: no valid result within %0d cycles", WAIT_LIMIT);
    end
  endtask

  task automatic check_outputs(input vex_pkg::fu_t fu, input vex_pkg::elem_t exp0,
                               input vex_pkg::elem_t exp1, input logic en0, input logic en1);
    check_val("out_valid", out_valid, 1);
    check_val("out_fu", out_fu, fu);
    check_val("out_wen0", out_wen0, en0 && (fu != vex_pkg::FU_STORE));
    check_val("out_wen1", out_wen1, en1 && (fu != vex_pkg::FU_STORE));
    if (en0) begin
      check_val("out_result0", out_result0, exp0);
    end
    if (en1) begin
      check_val("out_result1", out_result1, exp1);
    end
  endtask

  task automatic run_alu(input vex_pkg::alu_op_t op, input vex_pkg::src_t s1,
                         input vex_pkg::src_t s2, input logic en0, input logic en1);
    vex_pkg::elem_t v1a, v1b, v2a, v2b, x1, x2, im;
    vex_pkg::elem_t exp0, exp1;
    int             cycles;
    v1a = rand_elem();
    v1b = rand_elem();
    v2a = rand_elem();
    v2b = rand_elem();
    x1  = rand_elem();
    x2  = rand_elem();
    im  = rand_elem();
    exp0 = alu_model(op, pick_src(s1, v1a, im, x1), pick_src(s2, v2a, im, x2));
    exp1 = alu_model(op, pick_src(s1, v1b, im, x1), pick_src(s2, v2b, im, x2));
    @(posedge CLK);
    drive_operands(v1a, v1b, v2a, v2b, x1, x2, im);
    drive_op(vex_pkg::FU_ALU, op, s1, s2, en0, en1);
    @(posedge CLK);
    in_valid <= 1'b0;
    wait_valid(cycles);
    check_val("ALU latency", vex_pkg::elem_t'(cycles), 0);
    check_outputs(vex_pkg::FU_ALU, exp0, exp1, en0, en1);
  endtask

  // Inputs stay put until busy has fallen
  task automatic run_mul(input vex_pkg::elem_t a0, input vex_pkg::elem_t b0,
                         input vex_pkg::elem_t a1, input vex_pkg::elem_t b1);
    vex_pkg::elem_t exp0, exp1;
    logic           seen_busy, drop, done;
    int             n;
    exp0 = a0 * b0;
    exp1 = a1 * b1;
    seen_busy = 1'b0;
    drop = 1'b0;
    done = 1'b0;
    n = 0;
    @(posedge CLK);
    drive_operands(a0, a1, b0, b1, '0, '0, '0);
    drive_op(vex_pkg::FU_MUL, vex_pkg::ALU_ADD, vex_pkg::SRC_V, vex_pkg::SRC_V, 1'b1, 1'b1);
    while (!done && n < WAIT_LIMIT) begin
      @(posedge CLK);
      if (drop) begin
        in_valid <= 1'b0;
      end
      @(negedge CLK);
      n++;
      done = out_valid;
      // Result must come a cycle after busy has dropped
      if (done) begin
        check_val("busy low before result", drop, 1);
      end
      if (busy) begin
        seen_busy = 1'b1;
      end else if (seen_busy) begin
        drop = 1'b1;
      end
    end
    if (!done) begin
      errors++;
      $display("Timeout: multiply gave no result within %0d cycles", WAIT_LIMIT);
      @(posedge CLK);
      in_valid <= 1'b0;
    end
    check_val("busy during multiply", seen_busy, 1);
    check_val("busy at result", busy, 0);
    check_outputs(vex_pkg::FU_MUL, exp0, exp1, 1'b1, 1'b1);
  endtask

  task automatic run_iota();
    vex_pkg::elem_t     m0, m1, exp0, exp1;
    vex_pkg::vl_t       vlen;
    vex_pkg::elem_idx_t i0, i1;
    int                 cycles;
    m0   = rand_elem();
    m1   = rand_elem();
    vlen = vex_pkg::vl_t'($unsigned($random(seed)) % 65);
    i0   = vex_pkg::elem_idx_t'($random(seed));
    i1   = vex_pkg::elem_idx_t'($random(seed));
    exp0 = mask_count({m1, m0}, int'(vlen), int'(i0));
    exp1 = mask_count({m1, m0}, int'(vlen), int'(i1));
    @(posedge CLK);
    drive_operands('0, '0, m0, m1, '0, '0, '0);
    vl        <= vlen;
    elem_idx0 <= i0;
    elem_idx1 <= i1;
    drive_op(vex_pkg::FU_IOTA, vex_pkg::ALU_ADD, vex_pkg::SRC_V, vex_pkg::SRC_V, 1'b1, 1'b1);
    @(posedge CLK);
    in_valid <= 1'b0;
    wait_valid(cycles);
    check_outputs(vex_pkg::FU_IOTA, exp0, exp1, 1'b1, 1'b1);
  endtask

  // One element pair of a load or store run
  task automatic run_mem(input vex_pkg::fu_t fu, input vex_pkg::elem_idx_t e0, input logic str,
                         input logic idx, input vex_pkg::elem_t base, input vex_pkg::elem_t stride);
    vex_pkg::elem_t    v2a, v2b, sd0, sd1, step, exp0, exp1;
    vex_pkg::reg_idx_t rd;
    int                cycles;
    v2a  = rand_elem();
    v2b  = rand_elem();
    sd0  = rand_elem();
    sd1  = rand_elem();
    rd   = vex_pkg::reg_idx_t'($random(seed));
    step = str ? stride : 32'd4;
    if (idx) begin
      exp0 = base + v2a;
      exp1 = base + v2b;
    end else begin
      exp0 = base + vex_pkg::elem_t'(e0) * step;
      exp1 = base + (vex_pkg::elem_t'(e0) + 1) * step;
    end
    @(posedge CLK);
    drive_operands('0, '0, v2a, v2b, base, '0, '0);
    elem_idx0  <= e0;
    elem_idx1  <= vex_pkg::elem_idx_t'(e0 + 1);
    strided    <= str;
    indexed    <= idx;
    stride_val <= stride;
    storedata0 <= sd0;
    storedata1 <= sd1;
    vd         <= rd;
    drive_op(fu, vex_pkg::ALU_ADD, vex_pkg::SRC_X, vex_pkg::SRC_V, 1'b1, 1'b1);
    @(posedge CLK);
    in_valid <= 1'b0;
    wait_valid(cycles);
    check_outputs(fu, exp0, exp1, 1'b1, 1'b1);
    check_val("out_elem_idx0", out_elem_idx0, e0);
    check_val("out_elem_idx1", out_elem_idx1, vex_pkg::elem_idx_t'(e0 + 1));
    check_val("out_vd", out_vd, rd);
    if (fu == vex_pkg::FU_STORE) begin
      check_val("out_storedata0", out_storedata0, sd0);
      check_val("out_storedata1", out_storedata1, sd1);
    end
  endtask

  // Second instruction waits behind stall while the first stays on the outputs
  task automatic run_stall();
    vex_pkg::elem_t xa0, xa1, xb0, xb1, ya0, ya1, yb0, yb1;
    xa0 = rand_elem();
    xa1 = rand_elem();
    xb0 = rand_elem();
    xb1 = rand_elem();
    ya0 = rand_elem();
    ya1 = rand_elem();
    yb0 = rand_elem();
    yb1 = rand_elem();
    @(posedge CLK);
    drive_operands(xa0, xa1, xb0, xb1, '0, '0, '0);
    drive_op(vex_pkg::FU_ALU, vex_pkg::ALU_ADD, vex_pkg::SRC_V, vex_pkg::SRC_V, 1'b1, 1'b1);
    @(posedge CLK);
    drive_operands(ya0, ya1, yb0, yb1, '0, '0, '0);
    alu_op <= vex_pkg::ALU_XOR;
    stall  <= 1'b1;
    for (int k = 0; k < 4; k++) begin
      @(negedge CLK);
      check_val("out_valid under stall", out_valid, 1);
      check_val("out_result0 under stall", out_result0, xa0 + xb0);
      check_val("out_result1 under stall", out_result1, xa1 + xb1);
    end
    @(posedge CLK);
    stall <= 1'b0;
    @(posedge CLK);
    in_valid <= 1'b0;
    @(negedge CLK);
    check_outputs(vex_pkg::FU_ALU, ya0 ^ yb0, ya1 ^ yb1, 1'b1, 1'b1);
  endtask

  task automatic run_flush();
    logic seen;
    int   n;
    seen = 1'b0;
    n = 0;
    @(posedge CLK);
    // All-ones multiplier runs the full step count
    drive_operands(rand_elem(), rand_elem(), 32'hFFFF_FFFF, 32'hFFFF_FFFF, '0, '0, '0);
    drive_op(vex_pkg::FU_MUL, vex_pkg::ALU_ADD, vex_pkg::SRC_V, vex_pkg::SRC_V, 1'b1, 1'b1);
    while (!seen && n < WAIT_LIMIT) begin
      @(negedge CLK);
      n++;
      seen = busy;
    end
    if (!seen) begin
      errors++;
      $display("Timeout: multiply never raised busy before the flush");
    end
    @(posedge CLK);
    flush <= 1'b1;
    @(posedge CLK);
    flush    <= 1'b0;
    in_valid <= 1'b0;
    for (int k = 0; k < 4; k++) begin
      @(negedge CLK);
      check_val("out_valid after flush", out_valid, 0);
      check_val("out_wen0 after flush", out_wen0, 0);
      check_val("out_wen1 after flush", out_wen1, 0);
      check_val("busy after flush", busy, 0);
    end
  endtask

  initial begin
    vex_pkg::elem_t base;
    vex_pkg::elem_t stride;
    seed = 40;
    errors = 0;
    checks = 0;
    init_inputs();
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_val("out_valid after reset", out_valid, 0);
    check_val("out_wen0 after reset", out_wen0, 0);
    check_val("out_wen1 after reset", out_wen1, 0);
    check_val("busy after reset", busy, 0);

    // Every op and every pair of operand sources with some lanes off
    for (int k = 0; k < 18; k++) begin
      run_alu(vex_pkg::alu_op_t'(k % 9), vex_pkg::src_t'(k % 3), vex_pkg::src_t'((k / 3) % 3),
              1'b1, (k % 4) != 3);
    end

    run_mul(rand_elem(), rand_elem(), rand_elem(), rand_elem());
    run_mul(32'd7, 32'd13, 32'd0, rand_elem());
    run_mul(32'hFFFF_FFFF, 32'd3, 32'd12345, 32'd678);
    run_mul(rand_elem(), 32'h8000_0001, rand_elem(), 32'd1);

    for (int k = 0; k < 6; k++) begin
      run_iota();
    end

    base = rand_elem() & ~32'h3;
    run_mem(vex_pkg::FU_LOAD, 6'd0, 1'b0, 1'b0, base, '0);
    run_mem(vex_pkg::FU_LOAD, 6'd2, 1'b0, 1'b0, base, '0);
    run_mem(vex_pkg::FU_LOAD, 6'd4, 1'b0, 1'b0, base, '0);
    base   = rand_elem();
    stride = rand_elem() & 32'h0000_0FFC;
    run_mem(vex_pkg::FU_LOAD, 6'd0, 1'b1, 1'b0, base, stride);
    run_mem(vex_pkg::FU_STORE, 6'd2, 1'b1, 1'b0, base, stride);
    run_mem(vex_pkg::FU_LOAD, 6'd4, 1'b1, 1'b0, base, stride);
    run_mem(vex_pkg::FU_LOAD, 6'd8, 1'b0, 1'b1, rand_elem(), '0);
    run_mem(vex_pkg::FU_STORE, 6'd0, 1'b0, 1'b1, rand_elem(), '0);

    run_stall();
    run_flush();
    run_alu(vex_pkg::ALU_SUB, vex_pkg::SRC_V, vex_pkg::SRC_X, 1'b1, 1'b1);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
